//--- cart_pkg.sv
package cart_pkg;

    localparam int OFFSET_W = 26;

    // Register index, taken from bus address bits 5:2.
    typedef enum logic [3:0] {
        R_SCR,
        R_DDIPL_OFFSET,
        R_SAVE_OFFSET,
        R_COMMAND,
        R_DATA_0,
        R_DATA_1,
        R_VERSION,
        R_RECONFIGURE,
        R_ISV_OFFSET,
        R_ISV_RD_PTR,
        R_FLASH
    } reg_id_e;

    // SCR as the CPU sees it on a read.
    typedef struct packed {
        logic        cpu_ready;
        logic        cpu_busy;
        logic        rsvd_29;
        logic        cmd_error;
        logic [1:0]  rsvd_27_26;
        logic        flash_erase_busy;
        logic        flash_wp_active;
        logic [15:0] rsvd_23_8;
        logic        isv_enabled;
        logic        skip_bootloader;
        logic        flashram_enabled;
        logic        sram_banked;
        logic        sram_enabled;
        logic        dd_enabled;
        logic        sdram_writable;
        logic        sdram_switch;
    } scr_read_t;

    // SCR as the CPU writes it. Bits 27:24 become one-cycle flash strobes.
    typedef struct packed {
        logic        cpu_ready;
        logic        cpu_busy;
        logic        rsvd_29;
        logic        cmd_error;
        logic        flash_wp_disable;
        logic        flash_wp_enable;
        logic        rsvd_25;
        logic        flash_erase_start;
        logic [15:0] rsvd_23_8;
        logic        isv_enabled;
        logic        skip_bootloader;
        logic        flashram_enabled;
        logic        sram_banked;
        logic        sram_enabled;
        logic        dd_enabled;
        logic        sdram_writable;
        logic        sdram_switch;
    } scr_write_t;

    typedef union packed {
        scr_read_t   rd;
        scr_write_t  wr;
        logic [31:0] raw;
    } scr_word_u;

    localparam logic [OFFSET_W-1:0] DDIPL_OFFSET_RST = 26'h3BE_0000;
    localparam logic [OFFSET_W-1:0] SAVE_OFFSET_RST  = 26'h3FE_0000;
    localparam logic [OFFSET_W-1:0] ISV_OFFSET_RST   = 26'h3FF_0000;

    localparam logic [31:0] RECONFIGURE_MAGIC = 32'h5253_5446;
    localparam logic [31:0] CART_VERSION      = 32'h0002_0103;

    localparam logic [15:0] ERASE_CYCLES = 16'd20;

    // Erase controller states.
    localparam logic ST_IDLE    = 1'b0;
    localparam logic ST_ERASING = 1'b1;

endpackage

//--- cfg_top.sv
`timescale 1ns/1ps

module cfg_top (
    input  logic                          sys,
    input  logic                          rst_n,
    input  logic                          bus_request,
    input  logic [31:0]                   bus_address,
    input  logic [3:0]                    bus_wmask,
    input  logic [31:0]                   bus_wdata,
    output logic                          bus_ack,
    output logic [31:0]                   bus_rdata,
    input  logic                          cmd_valid,
    input  logic [7:0]                    cmd_byte,
    output logic                          cmd_ready,
    output logic [31:0]                   data_0,
    output logic [31:0]                   data_1,
    input  logic                          soft_reset,
    output logic                          reconfigure,
    output logic                          sdram_switch,
    output logic                          sdram_writable,
    output logic                          dd_enabled,
    output logic                          sram_enabled,
    output logic                          sram_banked,
    output logic                          flashram_enabled,
    output logic                          isv_enabled,
    output logic [cart_pkg::OFFSET_W-1:0] ddipl_offset,
    output logic [cart_pkg::OFFSET_W-1:0] save_offset,
    output logic [cart_pkg::OFFSET_W-1:0] isv_offset
);

    logic erase_start;
    logic wp_enable;
    logic wp_disable;
    logic erase_busy;
    logic wp_active;
    logic timer_load;
    logic timer_done;

    cpu_cfg_regs u_regs (
        .sys              (sys),
        .rst_n            (rst_n),
        .bus_request      (bus_request),
        .bus_address      (bus_address),
        .bus_wmask        (bus_wmask),
        .bus_wdata        (bus_wdata),
        .bus_ack          (bus_ack),
        .bus_rdata        (bus_rdata),
        .cmd_valid        (cmd_valid),
        .cmd_byte         (cmd_byte),
        .cmd_ready        (cmd_ready),
        .data_0           (data_0),
        .data_1           (data_1),
        .soft_reset       (soft_reset),
        .erase_busy       (erase_busy),
        .wp_active        (wp_active),
        .erase_start      (erase_start),
        .wp_enable        (wp_enable),
        .wp_disable       (wp_disable),
        .reconfigure      (reconfigure),
        .sdram_switch     (sdram_switch),
        .sdram_writable   (sdram_writable),
        .dd_enabled       (dd_enabled),
        .sram_enabled     (sram_enabled),
        .sram_banked      (sram_banked),
        .flashram_enabled (flashram_enabled),
        .isv_enabled      (isv_enabled),
        .ddipl_offset     (ddipl_offset),
        .save_offset      (save_offset),
        .isv_offset       (isv_offset)
    );

    flash_erase_fsm u_erase_fsm (
        .sys         (sys),
        .rst_n       (rst_n),
        .erase_start (erase_start),
        .wp_enable   (wp_enable),
        .wp_disable  (wp_disable),
        .timer_done  (timer_done),
        .erase_busy  (erase_busy),
        .wp_active   (wp_active),
        .timer_load  (timer_load)
    );

    erase_timer u_erase_timer (
        .sys   (sys),
        .rst_n (rst_n),
        .load  (timer_load),
        .done  (timer_done)
    );

endmodule

//--- cpu_cfg_regs.sv
`timescale 1ns/1ps

module cpu_cfg_regs (
    input  logic                          sys,
    input  logic                          rst_n,
    input  logic                          bus_request,
    input  logic [31:0]                   bus_address,
    input  logic [3:0]                    bus_wmask,
    input  logic [31:0]                   bus_wdata,
    output logic                          bus_ack,
    output logic [31:0]                   bus_rdata,
    input  logic                          cmd_valid,
    input  logic [7:0]                    cmd_byte,
    output logic                          cmd_ready,
    output logic [31:0]                   data_0,
    output logic [31:0]                   data_1,
    input  logic                          soft_reset,
    input  logic                          erase_busy,
    input  logic                          wp_active,
    output logic                          erase_start,
    output logic                          wp_enable,
    output logic                          wp_disable,
    output logic                          reconfigure,
    output logic                          sdram_switch,
    output logic                          sdram_writable,
    output logic                          dd_enabled,
    output logic                          sram_enabled,
    output logic                          sram_banked,
    output logic                          flashram_enabled,
    output logic                          isv_enabled,
    output logic [cart_pkg::OFFSET_W-1:0] ddipl_offset,
    output logic [cart_pkg::OFFSET_W-1:0] save_offset,
    output logic [cart_pkg::OFFSET_W-1:0] isv_offset
);

    cart_pkg::reg_id_e   req_id;
    cart_pkg::reg_id_e   ack_id;
    cart_pkg::scr_word_u scr_rd;
    cart_pkg::scr_word_u scr_wr;

    logic        cpu_ready;
    logic        cpu_busy;
    logic        cmd_error;
    logic        skip_bootloader;
    logic [7:0]  cmd_reg;
    logic [15:0] isv_current_rd_ptr;
    logic [15:0] isv_rd_ptr;
    logic        full_mask;
    logic        cmd_accept;

    assign req_id     = cart_pkg::reg_id_e'(bus_address[5:2]);
    assign full_mask  = &bus_wmask;
    assign scr_wr.raw = bus_wdata;
    assign cmd_ready  = ~cpu_busy;
    assign cmd_accept = cmd_valid && cmd_ready;

    always_comb begin
        scr_rd.raw                 = '0;
        scr_rd.rd.cpu_ready        = cpu_ready;
        scr_rd.rd.cpu_busy         = cpu_busy;
        scr_rd.rd.cmd_error        = cmd_error;
        scr_rd.rd.flash_erase_busy = erase_busy;
        scr_rd.rd.flash_wp_active  = wp_active;
        scr_rd.rd.isv_enabled      = isv_enabled;
        scr_rd.rd.skip_bootloader  = skip_bootloader;
        scr_rd.rd.flashram_enabled = flashram_enabled;
        scr_rd.rd.sram_banked      = sram_banked;
        scr_rd.rd.sram_enabled     = sram_enabled;
        scr_rd.rd.dd_enabled       = dd_enabled;
        scr_rd.rd.sdram_writable   = sdram_writable;
        scr_rd.rd.sdram_switch     = sdram_switch;
    end

    // Read data is only driven during the acknowledge cycle.
    always_comb begin
        bus_rdata = '0;
        if (bus_ack) begin
            case (ack_id)
                cart_pkg::R_SCR:          bus_rdata = scr_rd.raw;
                cart_pkg::R_DDIPL_OFFSET: bus_rdata = 32'(ddipl_offset);
                cart_pkg::R_SAVE_OFFSET:  bus_rdata = 32'(save_offset);
                cart_pkg::R_COMMAND:      bus_rdata = {24'd0, cmd_reg};
                cart_pkg::R_DATA_0:       bus_rdata = data_0;
                cart_pkg::R_DATA_1:       bus_rdata = data_1;
                cart_pkg::R_VERSION:      bus_rdata = cart_pkg::CART_VERSION;
                cart_pkg::R_RECONFIGURE:  bus_rdata = cart_pkg::RECONFIGURE_MAGIC;
                cart_pkg::R_ISV_OFFSET:   bus_rdata = 32'(isv_offset);
                cart_pkg::R_ISV_RD_PTR:   bus_rdata = {isv_current_rd_ptr, isv_rd_ptr};
                default:                  bus_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge sys) begin
        if (bus_request) begin
            ack_id <= req_id;
        end
        if (cmd_accept) begin
            cmd_reg <= cmd_byte;
        end
        if (bus_request && full_mask && req_id == cart_pkg::R_DATA_0) begin
            data_0 <= bus_wdata;
        end
        if (bus_request && full_mask && req_id == cart_pkg::R_DATA_1) begin
            data_1 <= bus_wdata;
        end
    end

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            bus_ack            <= 1'b0;
            cpu_ready          <= 1'b0;
            cpu_busy           <= 1'b0;
            cmd_error          <= 1'b0;
            erase_start        <= 1'b0;
            wp_enable          <= 1'b0;
            wp_disable         <= 1'b0;
            reconfigure        <= 1'b0;
            skip_bootloader    <= 1'b0;
            sdram_switch       <= 1'b0;
            sdram_writable     <= 1'b0;
            dd_enabled         <= 1'b0;
            sram_enabled       <= 1'b0;
            sram_banked        <= 1'b0;
            flashram_enabled   <= 1'b0;
            isv_enabled        <= 1'b0;
            ddipl_offset       <= cart_pkg::DDIPL_OFFSET_RST;
            save_offset        <= cart_pkg::SAVE_OFFSET_RST;
            isv_offset         <= cart_pkg::ISV_OFFSET_RST;
            isv_current_rd_ptr <= '0;
            isv_rd_ptr         <= '0;
        end else begin
            bus_ack     <= bus_request;
            erase_start <= 1'b0;
            wp_enable   <= 1'b0;
            wp_disable  <= 1'b0;

            // Console reset brings back the boot mapping.
            if (soft_reset) begin
                sdram_switch       <= skip_bootloader;
                sdram_writable     <= 1'b0;
                isv_current_rd_ptr <= '0;
            end

            if (cmd_accept) begin
                cpu_busy <= 1'b1;
            end

            if (bus_request) begin
                case (req_id)
                    cart_pkg::R_SCR: begin
                        if (bus_wmask[3]) begin
                            cpu_ready   <= scr_wr.wr.cpu_ready;
                            cpu_busy    <= scr_wr.wr.cpu_busy;
                            cmd_error   <= scr_wr.wr.cmd_error;
                            wp_enable   <= scr_wr.wr.flash_wp_enable;
                            wp_disable  <= scr_wr.wr.flash_wp_disable;
                            erase_start <= scr_wr.wr.flash_erase_start;
                        end
                        if (bus_wmask[0]) begin
                            isv_enabled      <= scr_wr.wr.isv_enabled;
                            skip_bootloader  <= scr_wr.wr.skip_bootloader;
                            flashram_enabled <= scr_wr.wr.flashram_enabled;
                            sram_banked      <= scr_wr.wr.sram_banked;
                            sram_enabled     <= scr_wr.wr.sram_enabled;
                            dd_enabled       <= scr_wr.wr.dd_enabled;
                            sdram_writable   <= scr_wr.wr.sdram_writable;
                            sdram_switch     <= scr_wr.wr.sdram_switch;
                        end
                    end
                    cart_pkg::R_DDIPL_OFFSET: begin
                        if (full_mask) begin
                            ddipl_offset <= bus_wdata[cart_pkg::OFFSET_W-1:0];
                        end
                    end
                    cart_pkg::R_SAVE_OFFSET: begin
                        if (full_mask) begin
                            save_offset <= bus_wdata[cart_pkg::OFFSET_W-1:0];
                        end
                    end
                    cart_pkg::R_ISV_OFFSET: begin
                        if (full_mask) begin
                            isv_offset <= bus_wdata[cart_pkg::OFFSET_W-1:0];
                        end
                    end
                    cart_pkg::R_RECONFIGURE: begin
                        if (full_mask && bus_wdata == cart_pkg::RECONFIGURE_MAGIC) begin
                            reconfigure <= 1'b1;
                        end
                    end
                    cart_pkg::R_ISV_RD_PTR: begin
                        if (&bus_wmask[3:2]) begin
                            isv_current_rd_ptr <= bus_wdata[31:16];
                        end
                        if (&bus_wmask[1:0]) begin
                            isv_rd_ptr <= bus_wdata[15:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // The CPU side never issues back-to-back requests.
    a_ack_single: assert property (@(posedge sys) disable iff (!rst_n)
        bus_ack |=> !bus_ack);

    // Software never turns protection on and starts an erase in one write.
    a_strobe_excl: assert property (@(posedge sys) disable iff (!rst_n)
        !(erase_start && wp_enable));

endmodule

//--- erase_timer.sv
`timescale 1ns/1ps

module erase_timer (
    input  logic sys,
    input  logic rst_n,
    input  logic load,
    output logic done
);

    logic [15:0] count;
    logic        running;

    // Done is high for the single cycle in which the count sits at zero.
    assign done = running && (count == '0);

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= cart_pkg::ERASE_CYCLES;
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 16'd1;
            end
        end
    end

endmodule

//--- flash_erase_fsm.sv
`timescale 1ns/1ps

module flash_erase_fsm (
    input  logic sys,
    input  logic rst_n,
    input  logic erase_start,
    input  logic wp_enable,
    input  logic wp_disable,
    input  logic timer_done,
    output logic erase_busy,
    output logic wp_active,
    output logic timer_load
);

    logic state;

    // An erase is only taken when idle and unprotected.
    assign timer_load = erase_start && (state == cart_pkg::ST_IDLE) && !wp_active;
    assign erase_busy = (state == cart_pkg::ST_ERASING);

    always_ff @(posedge sys or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cart_pkg::ST_IDLE;
            wp_active <= 1'b1;
        end else begin
            if (wp_enable) begin
                wp_active <= 1'b1;
            end else if (wp_disable) begin
                wp_active <= 1'b0;
            end

            case (state)
                cart_pkg::ST_IDLE: begin
                    if (timer_load) begin
                        state <= cart_pkg::ST_ERASING;
                    end
                end
                cart_pkg::ST_ERASING: begin
                    if (timer_done) begin
                        state <= cart_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    a_done_in_erase: assert property (@(posedge sys) disable iff (!rst_n)
        timer_done |-> state == cart_pkg::ST_ERASING);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_cfg_top -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

//--- tb.f
cart_pkg.sv
erase_timer.sv
flash_erase_fsm.sv
cpu_cfg_regs.sv
cfg_top.sv
tb_clk_gen.sv
tb_cfg_top.sv

//--- tb_cfg_top.sv
`timescale 1ns/1ps

module tb_cfg_top;

    localparam logic [3:0] OP_WRITE      = 4'd0;
    localparam logic [3:0] OP_READ       = 4'd1;
    localparam logic [3:0] OP_READ_SCR   = 4'd2;
    localparam logic [3:0] OP_CMD        = 4'd3;
    localparam logic [3:0] OP_SOFT_RESET = 4'd4;
    localparam logic [3:0] OP_RECONF     = 4'd5;
    localparam logic [3:0] OP_POLL_ERASE = 4'd6;
    localparam logic [3:0] OP_READY      = 4'd7;
    localparam logic [3:0] OP_ENABLES    = 4'd8;

    typedef struct packed {
        logic [3:0]        op;
        cart_pkg::reg_id_e id;
        logic [3:0]        mask;
        logic [31:0]       data;
        logic [31:0]       exp;
    } entry_t;

    logic                          sys;
    logic                          rst_n;
    logic                          bus_request;
    logic [31:0]                   bus_address;
    logic [3:0]                    bus_wmask;
    logic [31:0]                   bus_wdata;
    logic                          bus_ack;
    logic [31:0]                   bus_rdata;
    logic                          cmd_valid;
    logic [7:0]                    cmd_byte;
    logic                          cmd_ready;
    logic [31:0]                   data_0;
    logic [31:0]                   data_1;
    logic                          soft_reset;
    logic                          reconfigure;
    logic                          sdram_switch;
    logic                          sdram_writable;
    logic                          dd_enabled;
    logic                          sram_enabled;
    logic                          sram_banked;
    logic                          flashram_enabled;
    logic                          isv_enabled;
    logic [cart_pkg::OFFSET_W-1:0] ddipl_offset;
    logic [cart_pkg::OFFSET_W-1:0] save_offset;
    logic [cart_pkg::OFFSET_W-1:0] isv_offset;

    entry_t      table_q[$];
    logic        table_ready = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          seed = 32'ha863;
    logic [31:0] rnd[0:6];
    logic        reconf_at_req;
    logic        reconf_at_ack;

    tb_clk_gen u_clk_gen (
        .sys   (sys),
        .rst_n (rst_n)
    );

    cfg_top DUT (
        .sys(sys), .rst_n(rst_n),
        .bus_request(bus_request), .bus_address(bus_address),
        .bus_wmask(bus_wmask), .bus_wdata(bus_wdata),
        .bus_ack(bus_ack), .bus_rdata(bus_rdata),
        .cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .cmd_ready(cmd_ready),
        .data_0(data_0), .data_1(data_1), .soft_reset(soft_reset),
        .reconfigure(reconfigure), .sdram_switch(sdram_switch),
        .sdram_writable(sdram_writable), .dd_enabled(dd_enabled),
        .sram_enabled(sram_enabled), .sram_banked(sram_banked),
        .flashram_enabled(flashram_enabled), .isv_enabled(isv_enabled),
        .ddipl_offset(ddipl_offset), .save_offset(save_offset), .isv_offset(isv_offset)
    );

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_scr(input cart_pkg::scr_word_u got, input cart_pkg::scr_word_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            $display("[ERROR] scr got %h expected %h (busy %h/%h erase %h/%h wp %h/%h)",
                     got.raw, exp.raw, got.rd.cpu_busy, exp.rd.cpu_busy,
                     got.rd.flash_erase_busy, exp.rd.flash_erase_busy,
                     got.rd.flash_wp_active, exp.rd.flash_wp_active);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Expected SCR read word, built from the field layout of the read view.
    function automatic cart_pkg::scr_word_u scr_expect(input logic busy, input logic erase_busy,
                                                       input logic wp, input logic [7:0] features);
        cart_pkg::scr_word_u w;
        w.raw                 = '0;
        w.rd.cpu_busy         = busy;
        w.rd.flash_erase_busy = erase_busy;
        w.rd.flash_wp_active  = wp;
        w.raw[7:0]            = features;
        return w;
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_WRITE:      return "write";
            OP_READ:       return "read";
            OP_READ_SCR:   return "read scr";
            OP_CMD:        return "command";
            OP_SOFT_RESET: return "soft reset";
            OP_RECONF:     return "reconfigure";
            OP_POLL_ERASE: return "poll erase";
            OP_READY:      return "cmd_ready";
            default:       return "enables";
        endcase
    endfunction

    task automatic add_entry(input logic [3:0] op, input cart_pkg::reg_id_e id,
                             input logic [3:0] mask, input logic [31:0] data,
                             input logic [31:0] exp);
        entry_t e;
        e.op   = op;
        e.id   = id;
        e.mask = mask;
        e.data = data;
        e.exp  = exp;
        table_q.push_back(e);
    endtask

    // One request cycle, then the acknowledge cycle, then one idle cycle.
    task automatic bus_access(input cart_pkg::reg_id_e id, input logic [3:0] mask,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        bus_request   = 1'b1;
        bus_address   = {26'd0, id, 2'b00};
        bus_wmask     = mask;
        bus_wdata     = wdata;
        reconf_at_req = reconfigure;
        if (bus_ack) begin
            $display("bus_ack was already high when the request started");
            errors++;
        end
        @(posedge sys);
        #1;
        bus_request   = 1'b0;
        bus_address   = '0;
        bus_wmask     = '0;
        bus_wdata     = '0;
        reconf_at_ack = reconfigure;
        rdata         = bus_rdata;
        if (!bus_ack) begin
            $display("no bus_ack one cycle after the request");
            errors++;
        end
        @(posedge sys);
        #1;
        if (bus_ack) begin
            $display("bus_ack stayed high for a second cycle");
            errors++;
        end
        check_word("bus_rdata while idle", bus_rdata, 32'd0);
    endtask

    // Registers that also leave the DUT as ports must show the same value there.
    task automatic check_port(input cart_pkg::reg_id_e id, input logic [31:0] exp);
        case (id)
            cart_pkg::R_DDIPL_OFFSET: check_word("ddipl_offset", 32'(ddipl_offset), exp);
            cart_pkg::R_SAVE_OFFSET:  check_word("save_offset", 32'(save_offset), exp);
            cart_pkg::R_ISV_OFFSET:   check_word("isv_offset", 32'(isv_offset), exp);
            cart_pkg::R_DATA_0:       check_word("data_0", data_0, exp);
            cart_pkg::R_DATA_1:       check_word("data_1", data_1, exp);
            default: begin
            end
        endcase
    endtask

    task automatic check_enables(input logic [7:0] exp);
        check_bit("sdram_switch", sdram_switch, exp[0]);
        check_bit("sdram_writable", sdram_writable, exp[1]);
        check_bit("dd_enabled", dd_enabled, exp[2]);
        check_bit("sram_enabled", sram_enabled, exp[3]);
        check_bit("sram_banked", sram_banked, exp[4]);
        check_bit("flashram_enabled", flashram_enabled, exp[5]);
        check_bit("isv_enabled", isv_enabled, exp[7]);
    endtask

    task automatic run_entry(input entry_t e);
        cart_pkg::reg_id_e   id;
        cart_pkg::scr_word_u got_scr;
        cart_pkg::scr_word_u exp_scr;
        logic [31:0]         rdata;
        logic                busy;
        int                  waited;
        id          = e.id;
        exp_scr.raw = e.exp;
        case (e.op)
            OP_WRITE: bus_access(id, e.mask, e.data, rdata);
            OP_READ: begin
                bus_access(id, 4'b0000, 32'd0, rdata);
                check_word({"bus_rdata ", id.name()}, rdata, e.exp);
                check_port(id, e.exp);
            end
            OP_READ_SCR: begin
                bus_access(cart_pkg::R_SCR, 4'b0000, 32'd0, rdata);
                got_scr.raw = rdata;
                check_scr(got_scr, exp_scr);
            end
            OP_CMD: begin
                waited = 0;
                while (!cmd_ready && waited < 10) begin
                    @(posedge sys);
                    #1;
                    waited++;
                end
                if (!cmd_ready) begin
                    $display("cmd_ready never came high for the command source");
                    errors++;
                end else begin
                    cmd_valid = 1'b1;
                    cmd_byte  = e.data[7:0];
                    @(posedge sys);
                    #1;
                    // The source offers its next byte, which must wait while busy.
                    cmd_byte = e.data[7:0] + 8'd1;
                    check_bit("cmd_ready", cmd_ready, e.exp[0]);
                    @(posedge sys);
                    #1;
                    check_bit("cmd_ready", cmd_ready, e.exp[0]);
                    cmd_valid = 1'b0;
                    cmd_byte  = 8'd0;
                end
            end
            OP_SOFT_RESET: begin
                soft_reset = 1'b1;
                @(posedge sys);
                #1;
                soft_reset = 1'b0;
            end
            OP_RECONF: begin
                bus_access(cart_pkg::R_RECONFIGURE, 4'b1111, e.data, rdata);
                check_bit("reconfigure before write", reconf_at_req, 1'b0);
                check_bit("reconfigure", reconf_at_ack, e.exp[0]);
            end
            OP_POLL_ERASE: begin
                busy   = 1'b1;
                waited = 0;
                while (busy && waited < 32'(cart_pkg::ERASE_CYCLES) + 4) begin
                    bus_access(cart_pkg::R_SCR, 4'b0000, 32'd0, rdata);
                    got_scr.raw = rdata;
                    busy        = got_scr.rd.flash_erase_busy;
                    waited      = waited + 2;
                end
                check_bit("flash_erase_busy", busy, 1'b0);
                if (busy) begin
                    $display("erase still busy after %0d cycles of polling", waited);
                end
            end
            OP_READY: check_bit("cmd_ready", cmd_ready, e.exp[0]);
            default:  check_enables(e.exp[7:0]);
        endcase
    endtask

    task automatic build_table();
        for (int k = 0; k < 7; k++) begin
            rnd[k] = $random(seed);
        end
        // Reset state.
        add_entry(OP_READY, cart_pkg::R_SCR, 4'h0, 32'd0, 32'd1);
        add_entry(OP_ENABLES, cart_pkg::R_SCR, 4'h0, 32'd0, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(0, 0, 1, 8'h00));
        add_entry(OP_READ, cart_pkg::R_DDIPL_OFFSET, 4'h0, 32'd0, 32'(cart_pkg::DDIPL_OFFSET_RST));
        add_entry(OP_READ, cart_pkg::R_SAVE_OFFSET, 4'h0, 32'd0, 32'(cart_pkg::SAVE_OFFSET_RST));
        add_entry(OP_READ, cart_pkg::R_ISV_OFFSET, 4'h0, 32'd0, 32'(cart_pkg::ISV_OFFSET_RST));
        add_entry(OP_READ, cart_pkg::R_VERSION, 4'h0, 32'd0, cart_pkg::CART_VERSION);
        // Full-mask writes keep the low 26 bits of an offset.
        add_entry(OP_WRITE, cart_pkg::R_DDIPL_OFFSET, 4'hF, rnd[0], 32'd0);
        add_entry(OP_READ, cart_pkg::R_DDIPL_OFFSET, 4'h0, 32'd0, rnd[0] & 32'h03FF_FFFF);
        add_entry(OP_WRITE, cart_pkg::R_SAVE_OFFSET, 4'hF, rnd[1], 32'd0);
        add_entry(OP_READ, cart_pkg::R_SAVE_OFFSET, 4'h0, 32'd0, rnd[1] & 32'h03FF_FFFF);
        add_entry(OP_WRITE, cart_pkg::R_ISV_OFFSET, 4'hF, rnd[2], 32'd0);
        add_entry(OP_READ, cart_pkg::R_ISV_OFFSET, 4'h0, 32'd0, rnd[2] & 32'h03FF_FFFF);
        add_entry(OP_WRITE, cart_pkg::R_DATA_0, 4'hF, rnd[3], 32'd0);
        add_entry(OP_READ, cart_pkg::R_DATA_0, 4'h0, 32'd0, rnd[3]);
        add_entry(OP_WRITE, cart_pkg::R_DATA_1, 4'hF, rnd[4], 32'd0);
        add_entry(OP_READ, cart_pkg::R_DATA_1, 4'h0, 32'd0, rnd[4]);
        add_entry(OP_WRITE, cart_pkg::R_DDIPL_OFFSET, 4'h7, rnd[5], 32'd0);
        add_entry(OP_READ, cart_pkg::R_DDIPL_OFFSET, 4'h0, 32'd0, rnd[0] & 32'h03FF_FFFF);
        add_entry(OP_WRITE, cart_pkg::R_SAVE_OFFSET, 4'hC, rnd[5], 32'd0);
        add_entry(OP_READ, cart_pkg::R_SAVE_OFFSET, 4'h0, 32'd0, rnd[1] & 32'h03FF_FFFF);
        // Byte 0 only, so cpu_ready and the erase strobe in the upper bytes are dropped.
        add_entry(OP_WRITE, cart_pkg::R_SCR, 4'h1, 32'h8100_00DE, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(0, 0, 1, 8'hDE));
        add_entry(OP_ENABLES, cart_pkg::R_SCR, 4'h0, 32'd0, 32'h0000_00DE);
        // Command handshake.
        add_entry(OP_CMD, cart_pkg::R_COMMAND, 4'h0, 32'h0000_005A, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(1, 0, 1, 8'hDE));
        add_entry(OP_READ, cart_pkg::R_COMMAND, 4'h0, 32'd0, 32'h0000_005A);
        add_entry(OP_WRITE, cart_pkg::R_SCR, 4'h8, 32'd0, 32'd0);
        add_entry(OP_READY, cart_pkg::R_SCR, 4'h0, 32'd0, 32'd1);
        // Reconfiguration.
        add_entry(OP_RECONF, cart_pkg::R_RECONFIGURE, 4'hF, 32'h5253_5447, 32'd0);
        add_entry(OP_RECONF, cart_pkg::R_RECONFIGURE, 4'hF, cart_pkg::RECONFIGURE_MAGIC, 32'd1);
        // Erase, first while protected and then after protection is dropped.
        add_entry(OP_WRITE, cart_pkg::R_SCR, 4'h8, 32'h0100_0000, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(0, 0, 1, 8'hDE));
        add_entry(OP_WRITE, cart_pkg::R_SCR, 4'h8, 32'h0800_0000, 32'd0);
        add_entry(OP_WRITE, cart_pkg::R_SCR, 4'h8, 32'h0100_0000, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(0, 1, 0, 8'hDE));
        add_entry(OP_POLL_ERASE, cart_pkg::R_SCR, 4'h0, 32'd0, 32'd0);
        // Soft reset maps the bootloader back and clears the current read pointer.
        add_entry(OP_WRITE, cart_pkg::R_ISV_RD_PTR, 4'hF, rnd[6], 32'd0);
        add_entry(OP_READ, cart_pkg::R_ISV_RD_PTR, 4'h0, 32'd0, rnd[6]);
        add_entry(OP_SOFT_RESET, cart_pkg::R_SCR, 4'h0, 32'd0, 32'd0);
        add_entry(OP_READ_SCR, cart_pkg::R_SCR, 4'h0, 32'd0, scr_expect(0, 0, 0, 8'hDD));
        add_entry(OP_READ, cart_pkg::R_ISV_RD_PTR, 4'h0, 32'd0, {16'h0000, rnd[6][15:0]});
        add_entry(OP_ENABLES, cart_pkg::R_SCR, 4'h0, 32'd0, 32'h0000_00DD);
    endtask

    initial begin
        bus_request = 1'b0;
        bus_address = '0;
        bus_wmask   = '0;
        bus_wdata   = '0;
        cmd_valid   = 1'b0;
        cmd_byte    = '0;
        soft_reset  = 1'b0;
    end

    initial begin
        entry_t     e;
        cart_pkg::reg_id_e id;
        int         errs_before;
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge sys);
        #1;
        for (int i = 0; i < table_q.size(); i++) begin
            e           = table_q[i];
            id          = e.id;
            errs_before = errors;
            run_entry(e);
            $display("test %0d %s %s: %s", i, op_name(e.op), id.name(),
                     (errors == errs_before) ? "ok" : "FAIL");
        end
        $display("%0d tests run, %0d checks, %0d errors", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Each table entry gets a budget of 60 cycles.
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 60) @(posedge sys);
        $display("watchdog ran out after %0d cycles", table_q.size() * 60);
        $display("tests failed");
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic sys,
    output logic rst_n
);

    localparam real HALF_PERIOD = 2.0;

    initial begin
        sys = 1'b0;
        forever #(HALF_PERIOD) sys = ~sys;
    end

    // Reset is held low across the first three rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge sys);
        #1;
        rst_n = 1'b1;
    end

endmodule
